//--- Makefile
# Verilator build and run of the board testbench

VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
TOP ?= bbc_board_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= RESULT: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/bbc_macros.svh
// shared sizes, ROM bank numbers and mouse limits; include wherever one of them is needed
`ifndef BBC_MACROS_SVH
`define BBC_MACROS_SVH

// ==============================
// memory bus sizes
// ==============================
`define BBC_ADDR_W 19
`define BBC_ROM_WORDS 114688
`define BBC_RAM_BYTES 212992
// one 16 KB bank
`define BBC_BANK_OFF_W 14

// ==============================
// physical ROM banks
// ==============================
// model B images
`define BBC_BANK_B_OS 4'd0
`define BBC_BANK_B_MMFS 4'd1
`define BBC_BANK_B_RAMMAS 4'd2
`define BBC_BANK_B_BASIC 4'd3
// master images
`define BBC_BANK_M_ADFS157 4'd4
`define BBC_BANK_M_MAMMFS 4'd5
`define BBC_BANK_M_MOS 4'd6
`define BBC_BANK_M_DFS 4'd7
`define BBC_BANK_M_VIEWSHT 4'd8
`define BBC_BANK_M_EDIT 4'd9
`define BBC_BANK_M_BASIC4 4'd10
`define BBC_BANK_M_ADFS 4'd11
`define BBC_BANK_M_VIEW 4'd12
`define BBC_BANK_M_TERM 4'd13

// ==============================
// mouse to joystick emulation
// ==============================
`define BBC_MOUSE_STEP_MAX 10
`define BBC_AXIS_MIN (-128)
`define BBC_AXIS_MAX 127
`define BBC_JOY_W 12

`endif

//--- common/bbc_pkg.sv
// memory-address types shared by the memory blocks, the top level and the testbench
`include "bbc_macros.svh"

package bbc_pkg;

	// ==============================
	// ROM view of the bus address
	// ==============================
	// slot code picks a 16 KB ROM slot,
	// remapped per model to a physical bank
	typedef struct packed {
		logic region;
		logic [3:0] slot;
		logic [`BBC_BANK_OFF_W-1:0] offset;
	} mem_rom_view_s;

	// ==============================
	// RAM view of the bus address
	// ==============================
	// flat byte offset into the RAM store
	typedef struct packed {
		logic region;
		logic [`BBC_ADDR_W-2:0] offset;
	} mem_ram_view_s;

	// one 19-bit address, two decodes
	// region bit on top in both, 1 selects RAM
	typedef union packed {
		mem_rom_view_s rom;
		mem_ram_view_s ram;
	} mem_addr_u;

endpackage

//--- dv/bbc_board_assert.sv
// concurrent checks on the mouse position and the model flag; bound into mouse_axis and rom_bank_map
`timescale 1ns/1ps
`include "bbc_macros.svh"

module bbc_board_assert #(
	parameter bit mouse_checks = 1'b1,
	parameter bit model_checks = 1'b1
) (
	input logic clk_sys,
	input logic rst_n,
	input logic reset_req,
	input logic signed [7:0] pos_x,
	input logic signed [7:0] pos_y,
	input logic emu_on,
	input logic m128
);

	generate
		if (mouse_checks) begin : g_mouse
			logic signed [7:0] px_q;
			logic signed [7:0] py_q;
			logic signed [8:0] dx_d;
			logic signed [8:0] dy_d;

			// position one clock back
			always_ff @(posedge clk_sys) begin
				if (!rst_n) begin
					px_q <= '0;
					py_q <= '0;
				end else begin
					px_q <= pos_x;
					py_q <= pos_y;
				end
			end

			assign dx_d = pos_x - px_q;
			assign dy_d = pos_y - py_q;

			// ==============================
			// mouse properties
			// ==============================
			// a clear may drop straight to zero
			a_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
				(pos_x == 0 ||
					(dx_d <= `BBC_MOUSE_STEP_MAX && dx_d >= -`BBC_MOUSE_STEP_MAX)) &&
				(pos_y == 0 ||
					(dy_d <= `BBC_MOUSE_STEP_MAX && dy_d >= -`BBC_MOUSE_STEP_MAX)))
				else $error("mouse position moved by more than one step in a clock");

			a_clear: assert property (@(posedge clk_sys) disable iff (!rst_n)
				reset_req |=> (pos_x == 0 && pos_y == 0 && !emu_on))
				else $error("mouse state not cleared after a reset request");
		end

		if (model_checks) begin : g_model
			// flag only follows a sampled request
			a_model: assert property (@(posedge clk_sys) disable iff (!rst_n)
				!$stable(m128) |-> $past(reset_req))
				else $error("model flag changed without a reset request");
		end
	endgenerate

endmodule

bind mouse_axis bbc_board_assert #(
	.mouse_checks(1'b1),
	.model_checks(1'b0)
) u_assert (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.reset_req(reset_req),
	.pos_x(pos_x),
	.pos_y(pos_y),
	.emu_on(emu_on),
	.m128(1'b0)
);

bind rom_bank_map bbc_board_assert #(
	.mouse_checks(1'b0),
	.model_checks(1'b1)
) u_assert (
	.clk_sys(clk_sys),
	.rst_n(rst_n),
	.reset_req(reset_req),
	.pos_x(8'sd0),
	.pos_y(8'sd0),
	.emu_on(1'b0),
	.m128(m128)
);

//--- dv/bbc_board_tb.sv
// self-checking testbench for the board top; compile with tb.f and run bbc_board_tb as top
`timescale 1ns/1ps
`include "bbc_macros.svh"

module bbc_board_tb import bbc_pkg::*; ();

	localparam int reset_timeout = 50;

	logic clk_sys;
	logic rst_n;
	mem_addr_u mem_addr;
	logic mem_we_n;
	logic [7:0] mem_wdata;
	logic [7:0] mem_rdata;
	logic model_sel;
	logic reset_req;
	logic rom_load_wr;
	logic [16:0] rom_load_addr;
	logic [15:0] rom_load_data;
	logic [24:0] ps2_mouse;
	logic [15:0] joy1;
	logic [7:0] joy1_x;
	logic [7:0] joy1_y;
	logic mouse_off;
	logic [7:0] joy2_x;
	logic [7:0] joy2_y;
	logic joy2_fire;
	logic swap;
	logic [`BBC_JOY_W-1:0] joy1_ax;
	logic [`BBC_JOY_W-1:0] joy1_ay;
	logic [`BBC_JOY_W-1:0] joy2_ax;
	logic [`BBC_JOY_W-1:0] joy2_ay;
	logic joy1_fire_n;
	logic joy2_fire_n;

	// ==============================
	// reference model state
	// ==============================
	logic [15:0] rom_img [`BBC_ROM_WORDS];
	logic [7:0] ram_img [`BBC_RAM_BYTES];
	int ram_used [$];
	logic m128_m;
	logic emu_m;
	int mx;
	int my;
	logic [31:0] lcg_state = 32'h0e8751f3;
	int errors;
	int timeouts;
	int checks;

	tb_clk u_clk (.clk_sys(clk_sys), .rst_n(rst_n));

	bbc_board dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.mem_addr(mem_addr), .mem_we_n(mem_we_n), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .model_sel(model_sel), .reset_req(reset_req),
		.rom_load_wr(rom_load_wr), .rom_load_addr(rom_load_addr),
		.rom_load_data(rom_load_data), .ps2_mouse(ps2_mouse), .joy1(joy1),
		.joy1_x(joy1_x), .joy1_y(joy1_y), .mouse_off(mouse_off),
		.joy2_x(joy2_x), .joy2_y(joy2_y), .joy2_fire(joy2_fire), .swap(swap),
		.joy1_ax(joy1_ax), .joy1_ay(joy1_ay), .joy2_ax(joy2_ax), .joy2_ay(joy2_ay),
		.joy1_fire_n(joy1_fire_n), .joy2_fire_n(joy2_fire_n)
	);

	// lcg step, upper half folded into the low bits
	function automatic logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 16);
	endfunction

	// physical bank for a slot, -1 when empty
	function automatic int bank_of(input logic m, input logic [3:0] slot);
		int b;
		b = -1;
		if (!m) begin
			case (slot)
				4'b0100: b = 0;
				4'b1000: b = 1;
				4'b1110: b = 2;
				4'b1111: b = 3;
				default: b = -1;
			endcase
		end else if (slot == 4'b0010 || slot == 4'b0011) begin
			b = 2 + int'(slot);
		end else if (slot == 4'b0100) begin
			b = 6;
		end else if (slot >= 4'b1001) begin
			// 1001..1111 run on from bank 7
			b = int'(slot) - 2;
		end
		return b;
	endfunction

	function automatic logic [7:0] rom_byte(input logic m, input mem_addr_u a);
		int b;
		logic [15:0] w;
		b = bank_of(m, a.rom.slot);
		if (b < 0) begin
			return 8'h00;
		end
		w = rom_img[b * 8192 + int'(a.rom.offset) / 2];
		return a.rom.offset[0] ? w[7:0] : w[15:8];
	endfunction

	// signed v, offset by 128, then mirrored as 255 - x
	function automatic logic [`BBC_JOY_W-1:0] adc12(input logic [7:0] v);
		logic [7:0] t;
		t = 8'(127 - int'($signed(v)));
		return {t, t[7:4]};
	endfunction

	function automatic int clamp_step(input int d);
		if (d > `BBC_MOUSE_STEP_MAX) begin
			return `BBC_MOUSE_STEP_MAX;
		end else if (d < -`BBC_MOUSE_STEP_MAX) begin
			return -`BBC_MOUSE_STEP_MAX;
		end
		return d;
	endfunction

	function automatic int sat_axis(input int v);
		if (v < `BBC_AXIS_MIN) begin
			return `BBC_AXIS_MIN;
		end else if (v > `BBC_AXIS_MAX) begin
			return `BBC_AXIS_MAX;
		end
		return v;
	endfunction

	// ==============================
	// compare tasks
	// ==============================
	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_axis(input string name, input logic [`BBC_JOY_W-1:0] exp,
		input logic [`BBC_JOY_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// all six joystick outputs against the model and current inputs
	task automatic check_outputs(input string name);
		logic [7:0] x1;
		logic [7:0] y1;
		logic f1;
		x1 = emu_m ? 8'(mx) : joy1_x;
		y1 = emu_m ? 8'(my) : joy1_y;
		f1 = emu_m ? |ps2_mouse[1:0] : joy1[4];
		check_axis({name, " j1x"}, adc12(swap ? joy2_x : x1), joy1_ax);
		check_axis({name, " j1y"}, adc12(swap ? joy2_y : y1), joy1_ay);
		check_axis({name, " j2x"}, adc12(swap ? x1 : joy2_x), joy2_ax);
		check_axis({name, " j2y"}, adc12(swap ? y1 : joy2_y), joy2_ay);
		check_bit({name, " j1f"}, ~(swap ? joy2_fire : f1), joy1_fire_n);
		check_bit({name, " j2f"}, ~(swap ? f1 : joy2_fire), joy2_fire_n);
	endtask

	task automatic wait_reset_release(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < reset_timeout && !ok; n++) begin
			@(posedge clk_sys);
			ok = (rst_n === 1'b1);
		end
		if (!ok) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
	endtask

	// ==============================
	// memory stimulus
	// ==============================
	task automatic load_rom();
		int i;
		logic [15:0] w;
		for (i = 0; i < `BBC_ROM_WORDS; i++) begin
			w = 16'(rand32());
			rom_img[i] = w;
			@(posedge clk_sys);
			rom_load_wr <= 1'b1;
			rom_load_addr <= 17'(i);
			rom_load_data <= w;
		end
		@(posedge clk_sys);
		rom_load_wr <= 1'b0;
	endtask

	// address held two clocks, sampled mid-cycle after
	task automatic read_byte(input mem_addr_u a, output logic [7:0] d);
		@(posedge clk_sys);
		mem_addr <= a;
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		d = mem_rdata;
	endtask

	task automatic scan_rom(input string name, input int per_slot);
		mem_addr_u a;
		logic [7:0] d;
		int s;
		int k;
		for (s = 0; s < 16; s++) begin
			for (k = 0; k < per_slot; k++) begin
				a.rom.region = 1'b0;
				a.rom.slot = 4'(s);
				a.rom.offset = 14'(rand32());
				read_byte(a, d);
				check_byte($sformatf("%s slot %h off %h", name, a.rom.slot, a.rom.offset),
					rom_byte(m128_m, a), d);
			end
		end
	endtask

	task automatic pulse_reset_req();
		@(posedge clk_sys);
		reset_req <= 1'b1;
		@(posedge clk_sys);
		reset_req <= 1'b0;
		// latch and mouse clear both act on that edge
		m128_m = model_sel;
		emu_m = 1'b0;
		mx = 0;
		my = 0;
	endtask

	// later data bytes must not land while the strobe stays low
	task automatic ram_write(input int off, input logic [7:0] v, input int hold);
		mem_addr_u a;
		int k;
		a.ram.region = 1'b1;
		a.ram.offset = 18'(off);
		@(posedge clk_sys);
		mem_addr <= a;
		mem_wdata <= v;
		mem_we_n <= 1'b0;
		for (k = 1; k < hold; k++) begin
			@(posedge clk_sys);
			mem_wdata <= ~v;
		end
		@(posedge clk_sys);
		mem_we_n <= 1'b1;
		ram_img[off] = v;
	endtask

	// ==============================
	// mouse and stick stimulus
	// ==============================
	task automatic send_packet(input string name, input logic toggle);
		logic [24:0] p;
		p = 25'(rand32());
		p[24] = ps2_mouse[24] ^ toggle;
		// x mostly right, y mostly up, to reach both limits
		p[4] = p[4] & p[3];
		p[5] = p[5] & p[6];
		@(posedge clk_sys);
		ps2_mouse <= p;
		if (toggle) begin
			mx = sat_axis(mx + clamp_step(int'($signed({p[4], p[15:9]}))));
			my = sat_axis(my - clamp_step(int'($signed({p[5], p[23:17]}))));
			emu_m = 1'b1;
		end
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_outputs(name);
	endtask

	// kind 0 joy1 word, 1 reset request, 2 mouse off
	task automatic clear_by(input string name, input int kind);
		send_packet({name, " pre"}, 1'b1);
		@(posedge clk_sys);
		joy1_x <= 8'(rand32());
		joy1_y <= 8'(rand32());
		case (kind)
			0: joy1 <= 16'h0010;
			1: reset_req <= 1'b1;
			default: mouse_off <= 1'b1;
		endcase
		if (kind == 1) begin
			m128_m = model_sel;
		end
		emu_m = 1'b0;
		mx = 0;
		my = 0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_outputs({name, " held"});
		@(posedge clk_sys);
		joy1 <= '0;
		reset_req <= 1'b0;
		mouse_off <= 1'b0;
		// next packet starts again from zero
		send_packet({name, " post"}, 1'b1);
	endtask

	task automatic swap_checks(input string name, input int n);
		int i;
		logic [31:0] r;
		for (i = 0; i < n; i++) begin
			r = rand32();
			@(posedge clk_sys);
			joy2_x <= r[7:0];
			joy2_y <= r[15:8];
			joy2_fire <= r[16];
			swap <= r[17];
			@(negedge clk_sys);
			check_outputs($sformatf("%s %0d", name, i));
		end
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		bit ok;
		mem_addr_u a;
		logic [7:0] d;
		int i;
		mem_addr = '0;
		mem_we_n = 1'b1;
		mem_wdata = '0;
		model_sel = 1'b0;
		reset_req = 1'b0;
		rom_load_wr = 1'b0;
		rom_load_addr = '0;
		rom_load_data = '0;
		ps2_mouse = '0;
		joy1 = '0;
		joy1_x = 8'h30;
		joy1_y = 8'hc0;
		mouse_off = 1'b0;
		joy2_x = '0;
		joy2_y = '0;
		joy2_fire = 1'b0;
		swap = 1'b0;
		m128_m = 1'b0;
		emu_m = 1'b0;
		mx = 0;
		my = 0;
		errors = 0;
		timeouts = 0;
		checks = 0;
		wait_reset_release(ok);
		if (ok) begin
			load_rom();
			scan_rom("model_b", 4);
			// master map after a request, then held against model_sel
			@(posedge clk_sys);
			model_sel <= 1'b1;
			pulse_reset_req();
			scan_rom("master", 4);
			@(posedge clk_sys);
			model_sel <= 1'b0;
			scan_rom("master_held", 2);
			@(posedge clk_sys);
			model_sel <= 1'b1;
			for (i = 0; i < 24; i++) begin
				ram_used.push_back(int'(rand32() % `BBC_RAM_BYTES));
				ram_write(ram_used[i], 8'(rand32()), 2 + int'(rand32() % 3));
			end
			foreach (ram_used[j]) begin
				a.ram.region = 1'b1;
				a.ram.offset = 18'(ram_used[j]);
				read_byte(a, d);
				check_byte($sformatf("ram %h", ram_used[j]), ram_img[ram_used[j]], d);
			end
			// write strobe aimed at ROM
			a.rom.region = 1'b0;
			a.rom.slot = 4'b0100;
			a.rom.offset = 14'(rand32());
			@(posedge clk_sys);
			mem_addr <= a;
			mem_wdata <= 8'(rand32());
			mem_we_n <= 1'b0;
			@(posedge clk_sys);
			@(posedge clk_sys);
			mem_we_n <= 1'b1;
			read_byte(a, d);
			check_byte("rom_strobe", rom_byte(m128_m, a), d);
			for (i = 0; i < 60; i++) begin
				send_packet($sformatf("mouse %0d", i), (i % 4) != 3);
			end
			clear_by("clear_joy1", 0);
			clear_by("clear_reset", 1);
			clear_by("clear_off", 2);
			swap_checks("swap_emu", 16);
			@(posedge clk_sys);
			mouse_off <= 1'b1;
			emu_m = 1'b0;
			mx = 0;
			my = 0;
			swap_checks("swap_stick", 16);
		end
		$display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/tb_clk.sv
// testbench clock and reset source; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clk #(
	parameter int period_ns = 10,
	parameter int rst_cycles = 3
) (
	output logic clk_sys,
	output logic rst_n
);

	// free-running system clock
	initial begin
		clk_sys = 1'b0;
		forever #(period_ns / 2) clk_sys = ~clk_sys;
	end

	// reset low for a few edges, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

//--- logic/bbc_board.sv
// board top: external memory bus plus mouse emulation and joystick routing toward the core
`timescale 1ns/1ps
`include "bbc_macros.svh"

module bbc_board import bbc_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	// core memory bus
	input mem_addr_u mem_addr,
	input logic mem_we_n,
	input logic [7:0] mem_wdata,
	output logic [7:0] mem_rdata,
	input logic model_sel,
	input logic reset_req,
	// ROM image load
	input logic rom_load_wr,
	input logic [16:0] rom_load_addr,
	input logic [15:0] rom_load_data,
	// mouse and sticks
	input logic [24:0] ps2_mouse,
	input logic [15:0] joy1,
	input logic [7:0] joy1_x,
	input logic [7:0] joy1_y,
	input logic mouse_off,
	input logic [7:0] joy2_x,
	input logic [7:0] joy2_y,
	input logic joy2_fire,
	input logic swap,
	output logic [`BBC_JOY_W-1:0] joy1_ax,
	output logic [`BBC_JOY_W-1:0] joy1_ay,
	output logic [`BBC_JOY_W-1:0] joy2_ax,
	output logic [`BBC_JOY_W-1:0] joy2_ay,
	output logic joy1_fire_n,
	output logic joy2_fire_n
);

	// selected first-stick channel
	logic [7:0] ax;
	logic [7:0] ay;
	logic af;

	bbc_memory u_mem (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.mem_addr(mem_addr),
		.mem_we_n(mem_we_n),
		.mem_wdata(mem_wdata),
		.model_sel(model_sel),
		.reset_req(reset_req),
		.rom_load_wr(rom_load_wr),
		.rom_load_addr(rom_load_addr),
		.rom_load_data(rom_load_data),
		.mem_rdata(mem_rdata)
	);

	mouse_axis u_mouse (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.ps2_mouse(ps2_mouse),
		.joy1(joy1),
		.joy1_x(joy1_x),
		.joy1_y(joy1_y),
		.reset_req(reset_req),
		.mouse_off(mouse_off),
		.ax(ax),
		.ay(ay),
		.af(af)
	);

	joy_route u_joy (
		.ax(ax),
		.ay(ay),
		.af(af),
		.joy2_x(joy2_x),
		.joy2_y(joy2_y),
		.joy2_fire(joy2_fire),
		.swap(swap),
		.joy1_ax(joy1_ax),
		.joy1_ay(joy1_ay),
		.joy2_ax(joy2_ax),
		.joy2_ay(joy2_ay),
		.joy1_fire_n(joy1_fire_n),
		.joy2_fire_n(joy2_fire_n)
	);

endmodule

//--- logic/joy_route.sv
// converts both analog channels to the core's 12-bit form, inverts fires and applies the swap
`timescale 1ns/1ps
`include "bbc_macros.svh"

module joy_route import bbc_pkg::*; (
	input logic [7:0] ax,
	input logic [7:0] ay,
	input logic af,
	input logic [7:0] joy2_x,
	input logic [7:0] joy2_y,
	input logic joy2_fire,
	input logic swap,
	output logic [`BBC_JOY_W-1:0] joy1_ax,
	output logic [`BBC_JOY_W-1:0] joy1_ay,
	output logic [`BBC_JOY_W-1:0] joy2_ax,
	output logic [`BBC_JOY_W-1:0] joy2_ay,
	output logic joy1_fire_n,
	output logic joy2_fire_n
);

	logic [`BBC_JOY_W-1:0] emu_x;
	logic [`BBC_JOY_W-1:0] emu_y;
	logic [`BBC_JOY_W-1:0] stk_x;
	logic [`BBC_JOY_W-1:0] stk_y;

	// two's complement -> offset binary, then
	// mirrored so full left reads high on the ADC
	// upper nibble repeated to fill 12 bits
	function automatic logic [`BBC_JOY_W-1:0] to_adc(input logic [7:0] v);
		logic [7:0] t;
		t = 8'hff - {~v[7], v[6:0]};
		return {t, t[7:4]};
	endfunction

	// ==============================
	// channel conversion
	// ==============================
	assign emu_x = to_adc(ax);
	assign emu_y = to_adc(ay);
	assign stk_x = to_adc(joy2_x);
	assign stk_y = to_adc(joy2_y);

	// ==============================
	// player swap
	// ==============================
	// emulated channel normally on player 1
	assign joy1_ax = swap ? stk_x : emu_x;
	assign joy1_ay = swap ? stk_y : emu_y;
	assign joy2_ax = swap ? emu_x : stk_x;
	assign joy2_ay = swap ? emu_y : stk_y;

	// core fires are active low
	assign joy1_fire_n = swap ? ~joy2_fire : ~af;
	assign joy2_fire_n = swap ? ~af : ~joy2_fire;

endmodule

//--- logic/mouse_axis.sv
// mouse packets summed into a clamped analog position, muxed against the real first stick
`timescale 1ns/1ps
`include "bbc_macros.svh"

module mouse_axis import bbc_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input logic [24:0] ps2_mouse,
	input logic [15:0] joy1,
	input logic [7:0] joy1_x,
	input logic [7:0] joy1_y,
	input logic reset_req,
	input logic mouse_off,
	output logic [7:0] ax,
	output logic [7:0] ay,
	output logic af
);

	logic stb_q;
	logic packet;
	logic clear;
	logic emu_on;
	logic signed [7:0] pos_x;
	logic signed [7:0] pos_y;
	logic signed [8:0] dx;
	logic signed [8:0] dy;

	// clamp the raw delta, then add or subtract
	// and saturate to the axis range
	function automatic logic signed [7:0] axis_step(
		input logic signed [7:0] pos,
		input logic signed [8:0] raw,
		input logic sub
	);
		logic signed [8:0] step;
		logic signed [9:0] sum;
		if (raw > `BBC_MOUSE_STEP_MAX) begin
			step = 9'(`BBC_MOUSE_STEP_MAX);
		end else if (raw < -`BBC_MOUSE_STEP_MAX) begin
			step = 9'(-`BBC_MOUSE_STEP_MAX);
		end else begin
			step = raw;
		end
		sum = sub ? pos - step : pos + step;
		if (sum < `BBC_AXIS_MIN) begin
			return 8'(`BBC_AXIS_MIN);
		end else if (sum > `BBC_AXIS_MAX) begin
			return 8'(`BBC_AXIS_MAX);
		end
		return sum[7:0];
	endfunction

	// ==============================
	// packet decode
	// ==============================
	// sign bit on top of seven magnitude bits
	assign dx = {ps2_mouse[4], ps2_mouse[4], ps2_mouse[15:9]};
	assign dy = {ps2_mouse[5], ps2_mouse[5], ps2_mouse[23:17]};

	// toggle of bit 24 marks a new packet
	assign packet = stb_q ^ ps2_mouse[24];
	// any real stick activity drops emulation
	assign clear = (|joy1) | reset_req | mouse_off;

	// ==============================
	// position state
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			stb_q <= 1'b0;
			emu_on <= 1'b0;
			pos_x <= '0;
			pos_y <= '0;
		end else begin
			stb_q <= ps2_mouse[24];
			// clear wins over a packet in the same cycle
			if (clear) begin
				emu_on <= 1'b0;
				pos_x <= '0;
				pos_y <= '0;
			end else if (packet) begin
				emu_on <= 1'b1;
				pos_x <= axis_step(pos_x, dx, 1'b0);
				// mouse y grows upward
				pos_y <= axis_step(pos_y, dy, 1'b1);
			end
		end
	end

	// mouse buttons act as fire
	assign ax = emu_on ? pos_x : joy1_x;
	assign ay = emu_on ? pos_y : joy1_y;
	assign af = emu_on ? |ps2_mouse[1:0] : joy1[4];

endmodule

//--- memory/bbc_memory.sv
// external memory bus: RAM store, write-edge detect and ROM/RAM read select behind one address
`timescale 1ns/1ps
`include "bbc_macros.svh"

module bbc_memory import bbc_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input mem_addr_u mem_addr,
	input logic mem_we_n,
	input logic [7:0] mem_wdata,
	input logic model_sel,
	input logic reset_req,
	input logic rom_load_wr,
	input logic [16:0] rom_load_addr,
	input logic [15:0] rom_load_data,
	output logic [7:0] mem_rdata
);

	logic we_n_q;
	logic ram_wr;
	logic [7:0] ram_q;
	logic [7:0] rom_data;
	logic [7:0] ram [`BBC_RAM_BYTES];

	// ==============================
	// write strobe edge
	// ==============================
	// last strobe level, idle high
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			we_n_q <= 1'b1;
		end else begin
			we_n_q <= mem_we_n;
		end
	end

	// falling edge in RAM region only
	// held-low strobe gives one write
	assign ram_wr = mem_addr.ram.region & we_n_q & ~mem_we_n;

	// ==============================
	// RAM store
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			ram[mem_addr.ram.offset] <= mem_wdata;
		end
		ram_q <= ram[mem_addr.ram.offset];
	end

	rom_bank_map u_rom (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.addr(mem_addr),
		.model_sel(model_sel),
		.reset_req(reset_req),
		.rom_load_wr(rom_load_wr),
		.rom_load_addr(rom_load_addr),
		.rom_load_data(rom_load_data),
		.rom_data(rom_data)
	);

	// region bit picks the source
	assign mem_rdata = mem_addr.ram.region ? ram_q : rom_data;

endmodule

//--- memory/rom_bank_map.sv
// word-wide ROM store with a load port; maps slot codes to banks per model and returns one byte
`timescale 1ns/1ps
`include "bbc_macros.svh"

module rom_bank_map import bbc_pkg::*; (
	input logic clk_sys,
	input logic rst_n,
	input mem_addr_u addr,
	input logic model_sel,
	input logic reset_req,
	input logic rom_load_wr,
	input logic [16:0] rom_load_addr,
	input logic [15:0] rom_load_data,
	output logic [7:0] rom_data
);

	logic m128;
	logic [3:0] bank;
	logic mapped;
	logic [16:0] word_idx;
	logic [15:0] rom_word;
	logic [15:0] rom [`BBC_ROM_WORDS];

	// ==============================
	// model flag
	// ==============================
	// 0 = model B, 1 = master
	// follows model_sel only while the core asks for reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			m128 <= 1'b0;
		end else if (reset_req) begin
			m128 <= model_sel;
		end
	end

	// ==============================
	// slot to bank remap
	// ==============================
	always_comb begin
		mapped = 1'b1;
		case ({m128, addr.rom.slot})
			// model B
			5'b0_0100: bank = `BBC_BANK_B_OS;
			5'b0_1000: bank = `BBC_BANK_B_MMFS;
			5'b0_1110: bank = `BBC_BANK_B_RAMMAS;
			5'b0_1111: bank = `BBC_BANK_B_BASIC;
			// master
			5'b1_0010: bank = `BBC_BANK_M_ADFS157;
			5'b1_0011: bank = `BBC_BANK_M_MAMMFS;
			5'b1_0100: bank = `BBC_BANK_M_MOS;
			5'b1_1001: bank = `BBC_BANK_M_DFS;
			5'b1_1010: bank = `BBC_BANK_M_VIEWSHT;
			5'b1_1011: bank = `BBC_BANK_M_EDIT;
			5'b1_1100: bank = `BBC_BANK_M_BASIC4;
			5'b1_1101: bank = `BBC_BANK_M_ADFS;
			5'b1_1110: bank = `BBC_BANK_M_VIEW;
			5'b1_1111: bank = `BBC_BANK_M_TERM;
			default: begin
				// empty slot, data forced to zero below
				bank = 4'd0;
				mapped = 1'b0;
			end
		endcase
	end

	// bank * 8192 + offset / 2
	assign word_idx = {bank, addr.rom.offset[`BBC_BANK_OFF_W-1:1]};

	// ==============================
	// ROM store
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rom_load_wr) begin
			rom[rom_load_addr] <= rom_load_data;
		end
		rom_word <= rom[word_idx];
	end

	// even offset -> high byte, odd -> low byte
	assign rom_data = !mapped ? 8'h00 :
		addr.rom.offset[0] ? rom_word[7:0] : rom_word[15:8];

endmodule

//--- tb.f
+incdir+common
common/bbc_pkg.sv
memory/rom_bank_map.sv
memory/bbc_memory.sv
logic/mouse_axis.sv
logic/joy_route.sv
logic/bbc_board.sv
dv/tb_clk.sv
dv/bbc_board_assert.sv
dv/bbc_board_tb.sv
